// ==== logic/ninjin_pkg.sv ====
package ninjin_pkg;

  localparam int DWIDTH   = 16;
  localparam int RATE     = 4;
  localparam int RATELOG  = 2;
  localparam int BWIDTH   = RATE * DWIDTH;
  localparam int WORDSIZE = 24;
  localparam int MEMSIZE  = WORDSIZE + RATELOG;
  localparam int LWIDTH   = 16;
  localparam int BUFSIZE  = 8;
  localparam int LSB      = 3;

  typedef logic signed [DWIDTH-1:0]       word_t;
  // lane 0 sits in the low bits
  typedef word_t [RATE-1:0]               beat_t;
  typedef logic [WORDSIZE-1:0]            beat_addr_t;
  typedef logic [MEMSIZE-1:0]             mem_addr_t;
  typedef logic [WORDSIZE+LSB-1:0]        byte_addr_t;
  typedef logic [LWIDTH-1:0]              len_t;
  typedef logic [BUFSIZE-1:0]             buf_addr_t;

  typedef enum logic {
    DDR_READ  = 1'b0,
    DDR_WRITE = 1'b1
  } ddr_mode_e;

  typedef struct packed {
    logic       req;
    beat_addr_t base;
    len_t       read_len;
    len_t       write_len;
  } meta_t;

  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
  } mem_req_t;

  // unit-side commands carry the beat base and a word count
  typedef struct packed {
    logic       req;
    ddr_mode_e  mode;
    byte_addr_t base;
    len_t       len;
  } ddr_cmd_t;

  typedef struct packed {
    logic       we;
    beat_addr_t waddr;
    beat_t      wdata;
  } ddr_wr_t;

  // words to beats, rounded up, clamped to one burst
  function automatic len_t beat_len(len_t words, int unsigned max_beats);
    len_t beats;
    beats = (words >> RATELOG) + len_t'(|words[RATELOG-1:0]);
    if (beats > len_t'(max_beats))
      beats = len_t'(max_beats);
    return beats;
  endfunction

endpackage

// ==== logic/buf_ram.sv ====
`timescale 1ns/10ps

module buf_ram (
  input  logic                  clk,
  input  logic                  we,
  input  ninjin_pkg::buf_addr_t addr,
  input  ninjin_pkg::beat_t     wdata,
  output ninjin_pkg::beat_t     rdata
);

  import ninjin_pkg::*;

  beat_t mem_q [2**BUFSIZE];

  // read-first, one cycle latency
  always_ff @(posedge clk) begin
    if (we)
      mem_q[addr] <= wdata;
    rdata <= mem_q[addr];
  end

endmodule

// ==== logic/prefetch_unit.sv ====
`timescale 1ns/10ps

module prefetch_unit #(
  parameter int unsigned burst_max = 16
) (
  input  logic                 clk,
  input  logic                 xrst,
  input  ninjin_pkg::meta_t    meta,
  input  ninjin_pkg::mem_req_t mem,
  input  ninjin_pkg::ddr_wr_t  ddr_wr,
  output logic                 pre_ack,
  output ninjin_pkg::ddr_cmd_t rd_cmd,
  output ninjin_pkg::word_t    mem_rdata
);

  import ninjin_pkg::*;

  logic               req_q;
  logic               req_edge;
  logic               start_q;
  logic               loaded_q;
  beat_addr_t         base_q;
  len_t               rlen_q;
  len_t               nbeats;
  len_t               fill_cnt_q;
  logic               fill_we;
  logic               fill_last;
  beat_addr_t         fill_off;
  beat_addr_t         rd_off;
  buf_addr_t          ram_addr;
  beat_t              ram_rdata;
  logic [RATELOG-1:0] lane_q;
  logic               byp_q;
  word_t              byp_data_q;

  // ====================
  // request and fill
  // ====================

  assign req_edge  = meta.req && !req_q;
  assign nbeats    = beat_len(rlen_q, burst_max);
  assign fill_we   = !pre_ack && ddr_wr.we;
  assign fill_last = fill_we && fill_cnt_q == nbeats - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q      <= 1'b0;
      start_q    <= 1'b0;
      pre_ack    <= 1'b1;
      fill_cnt_q <= '0;
      loaded_q   <= 1'b0;
      byp_q      <= 1'b0;
      rd_cmd     <= '0;
    end else begin
      req_q       <= meta.req;
      start_q     <= req_edge;
      byp_q       <= mem.we;
      rd_cmd.req  <= start_q && nbeats != '0;
      rd_cmd.mode <= DDR_READ;
      rd_cmd.base <= byte_addr_t'(base_q);
      rd_cmd.len  <= rlen_q;
      if (start_q && nbeats != '0) begin
        pre_ack    <= 1'b0;
        fill_cnt_q <= '0;
        loaded_q   <= 1'b0;
      end else if (fill_we) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
        if (fill_last) begin
          pre_ack  <= 1'b1;
          loaded_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_edge) begin
      base_q <= meta.base;
      rlen_q <= meta.read_len;
    end
    lane_q     <= mem.addr[RATELOG-1:0];
    byp_data_q <= mem.wdata;
  end

  // ====================
  // prefetch ram
  // ====================

  // window offsets, DDR side while filling
  assign fill_off = ddr_wr.waddr - base_q;
  assign rd_off   = mem.addr[MEMSIZE-1:RATELOG] - base_q;
  assign ram_addr = pre_ack ? rd_off[BUFSIZE-1:0] : fill_off[BUFSIZE-1:0];

  buf_ram pre_ram (
    .clk   (clk),
    .we    (fill_we),
    .addr  (ram_addr),
    .wdata (ddr_wr.wdata),
    .rdata (ram_rdata)
  );

  // write bypass first, then the selected lane
  assign mem_rdata = byp_q    ? byp_data_q
                   : loaded_q ? ram_rdata[lane_q]
                   : '0;

endmodule

// ==== logic/post_unit.sv ====
`timescale 1ns/10ps

module post_unit #(
  parameter int unsigned burst_max = 16
) (
  input  logic                   clk,
  input  logic                   xrst,
  input  ninjin_pkg::meta_t      meta,
  input  ninjin_pkg::mem_req_t   mem,
  input  ninjin_pkg::beat_addr_t ddr_raddr,
  output ninjin_pkg::ddr_cmd_t   wr_cmd,
  output ninjin_pkg::beat_t      ddr_rdata
);

  import ninjin_pkg::*;

  localparam len_t MAX_WORDS = len_t'(RATE * burst_max);

  logic               req_q;
  logic               req_edge;
  len_t               wlen_clamp;
  len_t               wlen_q;
  len_t               cnt_q;
  logic               open_q;
  logic               wr_ok;
  logic               final_wr;
  logic [RATELOG-1:0] lane;
  beat_addr_t         post_base_q;
  beat_t              beat_q;
  logic               commit_q;
  buf_addr_t          commit_addr_q;
  logic               last_q;
  beat_addr_t         raddr_off;
  buf_addr_t          ram_addr;

  // ====================
  // write session
  // ====================

  assign req_edge   = meta.req && !req_q;
  assign wlen_clamp = meta.write_len > MAX_WORDS ? MAX_WORDS : meta.write_len;
  assign wr_ok      = mem.we && open_q;
  assign lane       = cnt_q[RATELOG-1:0];
  assign final_wr   = wr_ok && cnt_q == wlen_q - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q    <= 1'b0;
      wlen_q   <= '0;
      cnt_q    <= '0;
      open_q   <= 1'b0;
      commit_q <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      req_q    <= meta.req;
      // beat full or session done
      commit_q <= wr_ok && (&lane || final_wr);
      last_q   <= final_wr;
      if (req_edge) begin
        wlen_q <= wlen_clamp;
        cnt_q  <= '0;
        open_q <= wlen_clamp != '0;
      end else if (wr_ok) begin
        cnt_q <= cnt_q + 1'b1;
        if (final_wr)
          open_q <= 1'b0;
      end
    end
  end

  // beat packing, lane 0 clears the rest
  always_ff @(posedge clk) begin
    if (wr_ok && cnt_q == '0)
      post_base_q <= mem.addr[MEMSIZE-1:RATELOG];
    if (wr_ok) begin
      if (lane == '0)
        beat_q <= '0;
      beat_q[lane]  <= mem.wdata;
      commit_addr_q <= cnt_q[RATELOG +: BUFSIZE];
    end
  end

  // ====================
  // burst command
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_cmd <= '0;
    end else begin
      wr_cmd.req  <= last_q;
      wr_cmd.mode <= DDR_WRITE;
      wr_cmd.base <= byte_addr_t'(post_base_q);
      wr_cmd.len  <= wlen_q;
    end
  end

  // commits win, DDR reads come only after the command
  assign raddr_off = ddr_raddr - post_base_q;
  assign ram_addr  = commit_q ? commit_addr_q : raddr_off[BUFSIZE-1:0];

  buf_ram post_ram (
    .clk   (clk),
    .we    (commit_q),
    .addr  (ram_addr),
    .wdata (beat_q),
    .rdata (ddr_rdata)
  );

endmodule

// ==== logic/ddr_cmd_mux.sv ====
`timescale 1ns/10ps

module ddr_cmd_mux #(
  parameter int unsigned burst_max = 16
) (
  input  logic                 clk,
  input  logic                 xrst,
  input  ninjin_pkg::ddr_cmd_t rd_cmd,
  input  ninjin_pkg::ddr_cmd_t wr_cmd,
  output ninjin_pkg::ddr_cmd_t ddr_cmd
);

  import ninjin_pkg::*;

  ddr_cmd_t pend_q;
  ddr_cmd_t sel;

  // read first, then a held write
  always_comb begin
    if (rd_cmd.req)
      sel = rd_cmd;
    else if (pend_q.req)
      sel = pend_q;
    else
      sel = wr_cmd;
  end

  // one-deep slot for a colliding write
  always_ff @(posedge clk) begin
    if (!xrst)
      pend_q <= '0;
    else if (rd_cmd.req && wr_cmd.req)
      pend_q <= wr_cmd;
    else if (!rd_cmd.req)
      pend_q.req <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_cmd <= '0;
    end else begin
      ddr_cmd.req  <= sel.req;
      ddr_cmd.mode <= sel.mode;
      // beat to byte address
      ddr_cmd.base <= sel.base << LSB;
      ddr_cmd.len  <= beat_len(sel.len, burst_max);
    end
  end

endmodule

// ==== logic/ninjin_ddr_buf.sv ====
`timescale 1ns/10ps

module ninjin_ddr_buf #(
  parameter int unsigned burst_max = 16
) (
  input  logic                   clk,
  input  logic                   xrst,
  input  ninjin_pkg::meta_t      meta,
  input  ninjin_pkg::mem_req_t   mem,
  input  ninjin_pkg::ddr_wr_t    ddr_wr,
  input  ninjin_pkg::beat_addr_t ddr_raddr,
  output logic                   pre_ack,
  output ninjin_pkg::ddr_cmd_t   ddr_cmd,
  output ninjin_pkg::beat_t      ddr_rdata,
  output ninjin_pkg::word_t      mem_rdata
);

  import ninjin_pkg::*;

  ddr_cmd_t rd_cmd;
  ddr_cmd_t wr_cmd;

  // ====================
  // read side
  // ====================

  prefetch_unit #(
    .burst_max (burst_max)
  ) prefetch_unit_inst (
    .clk       (clk),
    .xrst      (xrst),
    .meta      (meta),
    .mem       (mem),
    .ddr_wr    (ddr_wr),
    .pre_ack   (pre_ack),
    .rd_cmd    (rd_cmd),
    .mem_rdata (mem_rdata)
  );

  // ====================
  // write side
  // ====================

  post_unit #(
    .burst_max (burst_max)
  ) post_unit_inst (
    .clk       (clk),
    .xrst      (xrst),
    .meta      (meta),
    .mem       (mem),
    .ddr_raddr (ddr_raddr),
    .wr_cmd    (wr_cmd),
    .ddr_rdata (ddr_rdata)
  );

  // ====================
  // ddr command port
  // ====================

  ddr_cmd_mux #(
    .burst_max (burst_max)
  ) ddr_cmd_mux_inst (
    .clk     (clk),
    .xrst    (xrst),
    .rd_cmd  (rd_cmd),
    .wr_cmd  (wr_cmd),
    .ddr_cmd (ddr_cmd)
  );

endmodule

// ==== tests/ddr_model.sv ====
`timescale 1ns/10ps

// behavioral DDR memory, one burst at a time
module ddr_model #(
  parameter int addr_bits = 8
) (
  input  logic                   clk,
  input  ninjin_pkg::ddr_cmd_t   ddr_cmd,
  input  ninjin_pkg::beat_t      ddr_rdata,
  output ninjin_pkg::ddr_wr_t    ddr_wr,
  output ninjin_pkg::beat_addr_t ddr_raddr
);

  import ninjin_pkg::*;

  beat_t mem_q [2**addr_bits];
  int    bursts_done;

  initial begin
    beat_addr_t base;
    len_t       n;
    void'($urandom(90660));
    for (int i = 0; i < 2**addr_bits; i++)
      mem_q[addr_bits'(i)] = {$urandom, $urandom};
    ddr_wr      = '0;
    ddr_raddr   = '0;
    bursts_done = 0;
    forever begin
      @(negedge clk);
      if (ddr_cmd.req) begin
        base = beat_addr_t'(ddr_cmd.base >> LSB);
        n    = ddr_cmd.len;
        if (ddr_cmd.mode == DDR_READ) begin
          // random gap before the first beat
          repeat (1 + $urandom % 4) @(negedge clk);
          for (len_t i = 0; i < n; i++) begin
            ddr_wr.we    = 1'b1;
            ddr_wr.waddr = base + beat_addr_t'(i);
            ddr_wr.wdata = mem_q[ddr_wr.waddr[addr_bits-1:0]];
            @(negedge clk);
          end
          ddr_wr.we = 1'b0;
        end else begin
          // beat comes back one cycle after its address
          for (len_t i = 0; i < n; i++) begin
            ddr_raddr = base + beat_addr_t'(i);
            @(negedge clk);
            mem_q[ddr_raddr[addr_bits-1:0]] = ddr_rdata;
          end
        end
        bursts_done++;
      end
    end
  end

endmodule

// ==== tests/tb_ninjin.sv ====
`timescale 1ns/10ps

module tb_ninjin;

  import ninjin_pkg::*;

  localparam int unsigned BURST_MAX      = 16;
  localparam int          MODEL_BITS     = 8;
  // words moved over all tests
  localparam int          TEST_WORDS     = 10 + 12 + 7 + 1 + 100;
  localparam int          TIMEOUT_CYCLES = 40 * TEST_WORDS + 200;
  localparam beat_addr_t  RD_BASE        = 24'h000020;
  localparam beat_addr_t  LONG_BASE      = 24'h000040;
  localparam beat_addr_t  WR_BASE        = 24'h000080;

  logic       clk;
  logic       xrst;
  meta_t      meta;
  mem_req_t   mem;
  ddr_wr_t    ddr_wr;
  beat_addr_t ddr_raddr;
  logic       pre_ack;
  ddr_cmd_t   ddr_cmd;
  beat_t      ddr_rdata;
  word_t      mem_rdata;
  int         bursts_before;

  ninjin_ddr_buf #(
    .burst_max (BURST_MAX)
  ) ninjin_ddr_buf_inst (
    .clk       (clk),
    .xrst      (xrst),
    .meta      (meta),
    .mem       (mem),
    .ddr_wr    (ddr_wr),
    .ddr_raddr (ddr_raddr),
    .pre_ack   (pre_ack),
    .ddr_cmd   (ddr_cmd),
    .ddr_rdata (ddr_rdata),
    .mem_rdata (mem_rdata)
  );

  ddr_model #(
    .addr_bits (MODEL_BITS)
  ) ddr_model_inst (
    .clk       (clk),
    .ddr_cmd   (ddr_cmd),
    .ddr_rdata (ddr_rdata),
    .ddr_wr    (ddr_wr),
    .ddr_raddr (ddr_raddr)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // lane (addr mod RATE) of beat (addr / RATE)
  function automatic word_t model_word(input mem_addr_t addr);
    beat_t b;
    b = ddr_model_inst.mem_q[addr[RATELOG +: MODEL_BITS]];
    return b[addr[RATELOG-1:0]];
  endfunction

  function automatic word_t write_data(input int k);
    return word_t'(32'h9e37 * k + 32'h0101);
  endfunction

  task automatic start_request(input beat_addr_t base, input len_t rlen, input len_t wlen);
    meta.req       = 1'b1;
    meta.base      = base;
    meta.read_len  = rlen;
    meta.write_len = wlen;
  endtask

  // trigger was driven at this falling edge
  task automatic expect_cmd(input ddr_mode_e mode, input beat_addr_t base, input len_t len);
    @(negedge clk);
    meta.req = 1'b0;
    mem.we   = 1'b0;
    check_val("ddr_cmd.req", 64'(ddr_cmd.req), 64'd0);
    if (mode == DDR_READ)
      check_val("pre_ack", 64'(pre_ack), 64'd1);
    @(negedge clk);
    check_val("ddr_cmd.req", 64'(ddr_cmd.req), 64'd0);
    if (mode == DDR_READ)
      check_val("pre_ack", 64'(pre_ack), 64'd0);
    @(negedge clk);
    check_val("ddr_cmd.req", 64'(ddr_cmd.req), 64'd1);
    check_val("ddr_cmd.mode", 64'(ddr_cmd.mode), 64'(mode));
    check_val("ddr_cmd.base", 64'(ddr_cmd.base), 64'(base) << LSB);
    check_val("ddr_cmd.len", 64'(ddr_cmd.len), 64'(len));
  endtask

  task automatic check_read(input mem_addr_t addr);
    mem.we   = 1'b0;
    mem.addr = addr;
    @(negedge clk);
    check_val("mem_rdata", 64'($unsigned(mem_rdata)), 64'($unsigned(model_word(addr))));
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_run("timeout, the DUT did not finish the tests in time");
  end

  initial begin
    xrst = 1'b0;
    meta = '0;
    mem  = '0;
    repeat (8) @(negedge clk);
    xrst = 1'b1;
    check_val("pre_ack", 64'(pre_ack), 64'd1);
    check_val("ddr_cmd.req", 64'(ddr_cmd.req), 64'd0);
    check_val("mem_rdata", 64'($unsigned(mem_rdata)), 64'd0);

    // ====================
    // short prefetch, 10 words in 3 beats
    @(negedge clk);
    start_request(RD_BASE, 16'd10, 16'd0);
    expect_cmd(DDR_READ, RD_BASE, 16'd3);
    while (!pre_ack) @(negedge clk);
    for (int k = 0; k < 12; k++)
      check_read({RD_BASE, 2'b00} + mem_addr_t'(k));

    // ====================
    // write session of 7 words
    start_request(24'h0, 16'd0, 16'd7);
    @(negedge clk);
    meta.req = 1'b0;
    for (int k = 0; k < 7; k++) begin
      mem.we    = 1'b1;
      mem.addr  = {WR_BASE, 2'b00} + mem_addr_t'(k);
      mem.wdata = write_data(k);
      if (k < 6)
        @(negedge clk);
    end
    bursts_before = ddr_model_inst.bursts_done;
    expect_cmd(DDR_WRITE, WR_BASE, 16'd2);
    while (ddr_model_inst.bursts_done == bursts_before) @(negedge clk);
    // last lane of the second beat stays zero
    for (int k = 0; k < 8; k++)
      check_val("model word", 64'($unsigned(model_word({WR_BASE, 2'b00} + mem_addr_t'(k)))),
                k < 7 ? 64'($unsigned(write_data(k))) : 64'd0);

    // write then read, bypass data
    mem.we    = 1'b1;
    mem.addr  = {RD_BASE, 2'b00};
    mem.wdata = 16'sh5a5a;
    @(negedge clk);
    mem.we = 1'b0;
    check_val("mem_rdata", 64'($unsigned(mem_rdata)), 64'h5a5a);

    // ====================
    // long request, clamped to one burst
    @(negedge clk);
    start_request(LONG_BASE, 16'd100, 16'd0);
    expect_cmd(DDR_READ, LONG_BASE, len_t'(BURST_MAX));
    while (!pre_ack) @(negedge clk);
    check_read({LONG_BASE, 2'b00} + mem_addr_t'(RATE * BURST_MAX - 1));

    @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== ninjin.f ====
logic/ninjin_pkg.sv
logic/buf_ram.sv
logic/prefetch_unit.sv
logic/post_unit.sv
logic/ddr_cmd_mux.sv
logic/ninjin_ddr_buf.sv
tests/ddr_model.sv
tests/tb_ninjin.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ninjin.f --top-module tb_ninjin -o sim_tb_ninjin
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_ninjin)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned an error"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
